// File: valu.f
+incdir+.
valu_pkg.sv
valu_result_if.sv
valu_insn_queue.sv
valu_issue.sv
valu_simd_alu.sv
valu_result_queue.sv
valu.sv
valu_tb.sv

// File: valu.sv
////////////////////////////////////////
// Vector ALU lane top
////////////////////////////////////////

`timescale 1ns/1ns

`include "valu_settings.svh"

module valu (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Instruction in
  input  logic                        insn_valid_i,
  input  valu_pkg::valu_op_e          insn_op_i,
  input  valu_pkg::vew_e              insn_vew_i,
  input  valu_pkg::vlen_t             insn_vl_i,
  input  valu_pkg::vreg_t             insn_vd_i,
  input  valu_pkg::vid_t              insn_id_i,
  input  logic                        insn_use_scalar_i,
  input  logic [63:0]                 insn_scalar_i,
  output logic                        insn_ready_o,
  // Operand streams
  input  logic [63:0]                 operand_a_i,
  input  logic                        operand_a_valid_i,
  output logic                        operand_a_ready_o,
  input  logic [63:0]                 operand_b_i,
  input  logic                        operand_b_valid_i,
  output logic                        operand_b_ready_o,
  // Register file writes
  output logic                        result_req_o,
  output valu_pkg::vid_t              result_id_o,
  output logic [`VALU_ADDR_WIDTH-1:0] result_addr_o,
  output logic [63:0]                 result_wdata_o,
  output logic [7:0]                  result_be_o,
  input  logic                        result_gnt_i,
  output logic [`VALU_NR_IDS-1:0]     vinsn_done_o
);

  valu_pkg::vinsn_t insn;
  valu_pkg::vinsn_t issue_insn;
  logic             issue_valid;
  logic             issue_done;
  logic             commit;
  valu_pkg::vid_t   commit_id;

  valu_result_if res_if ();

  assign insn = '{
    op:         insn_op_i,
    vew:        insn_vew_i,
    vl:         insn_vl_i,
    vd:         insn_vd_i,
    id:         insn_id_i,
    use_scalar: insn_use_scalar_i,
    scalar:     insn_scalar_i
  };

  valu_insn_queue i_insn_queue (
    .clk_i, .rst_ni, .insn_valid_i, .insn_i(insn), .insn_ready_o,
    .issue_valid_o(issue_valid), .issue_insn_o(issue_insn), .issue_done_i(issue_done),
    .commit_i(commit), .commit_id_i(commit_id), .vinsn_done_o
  );

  valu_issue i_issue (
    .clk_i, .rst_ni, .issue_valid_i(issue_valid), .insn_i(issue_insn),
    .issue_done_o(issue_done), .operand_a_i, .operand_b_i,
    .operand_a_valid_i, .operand_b_valid_i, .operand_a_ready_o, .operand_b_ready_o,
    .res(res_if.issue)
  );

  valu_result_queue i_result_queue (
    .clk_i, .rst_ni, .res(res_if.queue), .result_req_o, .result_id_o, .result_addr_o,
    .result_wdata_o, .result_be_o, .result_gnt_i, .commit_o(commit), .commit_id_o(commit_id)
  );

endmodule

// File: valu_insn_queue.sv
////////////////////////////////////////
// Vector instruction queue
////////////////////////////////////////

`timescale 1ns/1ns

`include "valu_settings.svh"

module valu_insn_queue (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     insn_valid_i,
  input  valu_pkg::vinsn_t         insn_i,
  output logic                     insn_ready_o,
  output logic                     issue_valid_o,
  output valu_pkg::vinsn_t         issue_insn_o,
  input  logic                     issue_done_i,
  input  logic                     commit_i,
  input  valu_pkg::vid_t           commit_id_i,
  output logic [`VALU_NR_IDS-1:0]  vinsn_done_o
);

  localparam int unsigned depth = `VALU_INSN_DEPTH;
  localparam int unsigned pw    = $clog2(depth);

  typedef logic [pw-1:0] pnt_t;
  typedef logic [pw:0]   cnt_t;

  // Storage of in-flight instructions
  valu_pkg::vinsn_t mem_q [depth];

  // Ring positions for accept, issue and commit
  pnt_t accept_pnt_q;
  pnt_t issue_pnt_q;
  pnt_t commit_pnt_q;
  // Entries still to issue, and entries not yet retired
  cnt_t issue_cnt_q;
  cnt_t commit_cnt_q;

  logic [`VALU_NR_IDS-1:0] done_q;
  logic                    accept;

  function automatic pnt_t next_pnt(pnt_t p);
    next_pnt = (p == pnt_t'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // Full until the oldest entry retires
  assign insn_ready_o  = (commit_cnt_q != depth);
  assign accept        = insn_valid_i && insn_ready_o;

  // Head instruction not yet fully issued
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_insn_o  = mem_q[issue_pnt_q];

  assign vinsn_done_o  = done_q;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_q       <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= next_pnt(accept_pnt_q);
      end
      if (issue_done_i) begin
        issue_pnt_q <= next_pnt(issue_pnt_q);
      end
      if (commit_i) begin
        commit_pnt_q <= next_pnt(commit_pnt_q);
      end
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_i);
      // Done bit for one cycle after the last grant
      done_q <= '0;
      if (commit_i) begin
        done_q[commit_id_i] <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Accepted length fits one register at its element width
  a_accept_vl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (insn_i.vl != '0) && (insn_i.vl <= (`VALU_MAX_VL >> insn_i.vew)));

  // Issue ends only an instruction still waiting to issue
  a_issue_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_done_i |-> (issue_cnt_q != '0));

  // Commit only for the oldest entry after it has finished issuing
  a_commit_oldest: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_i |-> (commit_cnt_q > issue_cnt_q) && (commit_id_i == mem_q[commit_pnt_q].id));

endmodule

// File: valu_issue.sv
////////////////////////////////////////
// Vector ALU issue stage
////////////////////////////////////////

`timescale 1ns/1ns

`include "valu_settings.svh"

module valu_issue (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             issue_valid_i,
  input  valu_pkg::vinsn_t insn_i,
  output logic             issue_done_o,
  input  logic [63:0]      operand_a_i,
  input  logic [63:0]      operand_b_i,
  input  logic             operand_a_valid_i,
  input  logic             operand_b_valid_i,
  output logic             operand_a_ready_o,
  output logic             operand_b_ready_o,
  valu_result_if.issue     res
);

  localparam int unsigned idx_w = $clog2(`VALU_REG_WORDS);

  // Set once the head instruction has issued a word
  logic                  active_q;
  valu_pkg::vlen_t       remain_q;
  logic [idx_w-1:0]      word_idx_q;

  valu_pkg::vlen_t       remain;
  valu_pkg::vlen_t       remain_next;
  logic [idx_w-1:0]      word_idx;
  logic [3:0]            elem_cnt;
  logic [3:0]            byte_cnt;
  logic [7:0]            be;
  logic                  last;
  logic                  operands_ok;
  logic                  fire;

  valu_pkg::simd_word_u  scalar_rep;
  valu_pkg::simd_word_u  alu_a;
  valu_pkg::simd_word_u  alu_b;
  valu_pkg::simd_word_u  alu_res;

  // A fresh head starts from its full length without a load cycle
  assign remain   = active_q ? remain_q : insn_i.vl;
  assign word_idx = active_q ? word_idx_q : '0;

  // Elements in this word, capped by what is left
  always_comb begin
    elem_cnt = valu_pkg::elems_per_word[insn_i.vew];
    if (remain < valu_pkg::vlen_t'(elem_cnt)) begin
      elem_cnt = remain[3:0];
    end
  end

  assign remain_next = remain - valu_pkg::vlen_t'(elem_cnt);
  assign last        = (remain_next == '0);

  // Low bytes of the active elements
  assign byte_cnt = elem_cnt << insn_i.vew;
  assign be       = ~(8'hff << byte_cnt);

  ////////////////////////////////////////
  // Operands
  ////////////////////////////////////////

  // Low scalar element copied into every lane
  always_comb begin
    unique case (insn_i.vew)
      valu_pkg::EW8:  scalar_rep.d = {8{insn_i.scalar[7:0]}};
      valu_pkg::EW16: scalar_rep.d = {4{insn_i.scalar[15:0]}};
      valu_pkg::EW32: scalar_rep.d = {2{insn_i.scalar[31:0]}};
      default:        scalar_rep.d = insn_i.scalar;
    endcase
  end

  assign alu_a.d = insn_i.use_scalar ? scalar_rep.d : operand_a_i;
  assign alu_b.d = operand_b_i;

  valu_simd_alu i_simd_alu (
    .op_i        (insn_i.op),
    .vew_i       (insn_i.vew),
    .operand_a_i (alu_a),
    .operand_b_i (alu_b),
    .result_o    (alu_res)
  );

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  // Stream a is not needed with a scalar
  assign operands_ok = (operand_a_valid_i || insn_i.use_scalar) && operand_b_valid_i;
  assign res.valid   = issue_valid_i && operands_ok;
  assign fire        = res.valid && res.ready;

  // Operands are consumed in the cycle their word moves
  assign operand_a_ready_o = fire && !insn_i.use_scalar;
  assign operand_b_ready_o = fire;
  assign issue_done_o      = fire && last;

  // Register vd starts at vd * VALU_REG_WORDS
  assign res.payload = '{
    id:    insn_i.id,
    addr:  valu_pkg::vaddr_t'(int'(insn_i.vd) * `VALU_REG_WORDS + int'(word_idx)),
    wdata: alu_res.d,
    be:    be,
    last:  last
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q   <= 1'b0;
      remain_q   <= '0;
      word_idx_q <= '0;
    end else if (fire) begin
      // Back to idle after the last word
      active_q   <= !last;
      remain_q   <= remain_next;
      word_idx_q <= word_idx + 1'b1;
    end
  end

  // Word held while the result queue is full
  a_payload_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res.valid && !res.ready |=> res.valid && $stable(res.payload));

endmodule

// File: valu_pkg.sv
////////////////////////////////////////
// Vector ALU lane types
////////////////////////////////////////

`include "valu_settings.svh"

package valu_pkg;

  // Element width, a word holds 8 >> vew elements
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [3:0] {
    VADD, VSUB, VAND, VOR, VXOR,
    VMIN, VMINU, VMAX, VMAXU,
    VSLL, VSRL
  } valu_op_e;

  typedef logic [$clog2(`VALU_NR_IDS)-1:0] vid_t;
  typedef logic [`VALU_VL_WIDTH-1:0]       vlen_t;
  typedef logic [4:0]                      vreg_t;
  typedef logic [`VALU_ADDR_WIDTH-1:0]     vaddr_t;

  // Elements per 64-bit word, indexed by vew
  localparam logic [3:0][3:0] elems_per_word = {4'd1, 4'd2, 4'd4, 4'd8};

  typedef struct packed {
    valu_op_e    op;
    vew_e        vew;
    vlen_t       vl;
    vreg_t       vd;
    vid_t        id;
    logic        use_scalar;
    logic [63:0] scalar;
  } vinsn_t;

  // One datapath word, seen per element width
  typedef union packed {
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] w;
    logic [63:0]      d;
  } simd_word_u;

  // Register file write request, last marks the final word of an instruction
  typedef struct packed {
    vid_t        id;
    vaddr_t      addr;
    logic [63:0] wdata;
    logic [7:0]  be;
    logic        last;
  } vresult_t;

endpackage

// File: valu_result_if.sv
////////////////////////////////////////
// Result word handshake
////////////////////////////////////////

`timescale 1ns/1ns

interface valu_result_if;

  // Word moves on a rising edge with valid and ready both high
  logic               valid;
  logic               ready;
  // Address, data, byte enables, id and last flag
  valu_pkg::vresult_t payload;

  // Producer side, holds payload steady until ready
  modport issue (
    output valid,
    output payload,
    input  ready
  );

  // Consumer side, ready while there is room
  modport queue (
    input  valid,
    input  payload,
    output ready
  );

endinterface

// File: valu_result_queue.sv
////////////////////////////////////////
// Result queue to the register file
////////////////////////////////////////

`timescale 1ns/1ns

`include "valu_settings.svh"

module valu_result_queue (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  valu_result_if.queue                res,
  output logic                        result_req_o,
  output valu_pkg::vid_t              result_id_o,
  output logic [`VALU_ADDR_WIDTH-1:0] result_addr_o,
  output logic [63:0]                 result_wdata_o,
  output logic [7:0]                  result_be_o,
  input  logic                        result_gnt_i,
  output logic                        commit_o,
  output valu_pkg::vid_t              commit_id_o
);

  localparam int unsigned depth = `VALU_RESULT_DEPTH;
  localparam int unsigned pw    = $clog2(depth);

  typedef logic [pw-1:0] pnt_t;
  typedef logic [pw:0]   cnt_t;

  valu_pkg::vresult_t mem_q [depth];
  pnt_t               rd_pnt_q;
  pnt_t               wr_pnt_q;
  cnt_t               cnt_q;

  valu_pkg::vresult_t head;
  logic               push;
  logic               pop;

  function automatic pnt_t next_pnt(pnt_t p);
    next_pnt = (p == pnt_t'(depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign res.ready = (cnt_q != depth);
  assign push      = res.valid && res.ready;
  assign head      = mem_q[rd_pnt_q];

  // Head word requests the register file
  assign result_req_o   = (cnt_q != '0);
  assign pop            = result_req_o && result_gnt_i;
  assign result_id_o    = head.id;
  assign result_addr_o  = head.addr;
  assign result_wdata_o = head.wdata;
  assign result_be_o    = head.be;

  // Instruction retires with its last word
  assign commit_o    = pop && head.last;
  assign commit_id_o = head.id;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_pnt_q] <= res.payload;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pnt_q <= '0;
      wr_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_pnt_q <= next_pnt(wr_pnt_q);
      end
      if (pop) begin
        rd_pnt_q <= next_pnt(rd_pnt_q);
      end
      cnt_q <= cnt_q + cnt_t'(push) - cnt_t'(pop);
    end
  end

  // Pointers meet only when empty or full, so no push ever overran the head
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_pnt_q == wr_pnt_q) |-> (cnt_q == '0) || (cnt_q == depth));

  a_gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_gnt_i |-> result_req_o);

endmodule

// File: valu_settings.svh
////////////////////////////////////////
// Vector ALU lane settings
////////////////////////////////////////

`ifndef VALU_SETTINGS_SVH
`define VALU_SETTINGS_SVH

// Instructions held between accept and retirement
`define VALU_INSN_DEPTH 4

// Result words buffered towards the register file
`define VALU_RESULT_DEPTH 2

// Largest vector length in elements, reached at 8-bit elements
`define VALU_MAX_VL 64
`define VALU_VL_WIDTH 7

// Register file layout of this lane
// 64-bit words per vector register
`define VALU_REG_WORDS 8
`define VALU_ADDR_WIDTH 8

// Instruction ids in flight across the machine
`define VALU_NR_IDS 8

`endif

// File: valu_simd_alu.sv
////////////////////////////////////////
// SIMD integer datapath
////////////////////////////////////////

`timescale 1ns/1ns

module valu_simd_alu (
  input  valu_pkg::valu_op_e   op_i,
  input  valu_pkg::vew_e       vew_i,
  input  valu_pkg::simd_word_u operand_a_i,
  input  valu_pkg::simd_word_u operand_b_i,
  output valu_pkg::simd_word_u result_o
);

  // One element of width w, zero-extended in and truncated by the caller
  function automatic logic [63:0] elem_op(valu_pkg::valu_op_e op, logic [63:0] a,
                                          logic [63:0] b, logic [6:0] w);
    logic        lt_u;
    logic        lt_s;
    logic [63:0] shamt;
    lt_u  = (a < b);
    // Differing sign bits decide alone
    lt_s  = (a[w-1] != b[w-1]) ? a[w-1] : lt_u;
    // Low log2(w) bits of b
    shamt = b & 64'(w - 7'd1);
    unique case (op)
      valu_pkg::VADD:  elem_op = a + b;
      valu_pkg::VSUB:  elem_op = a - b;
      valu_pkg::VAND:  elem_op = a & b;
      valu_pkg::VOR:   elem_op = a | b;
      valu_pkg::VXOR:  elem_op = a ^ b;
      valu_pkg::VMIN:  elem_op = lt_s ? a : b;
      valu_pkg::VMINU: elem_op = lt_u ? a : b;
      valu_pkg::VMAX:  elem_op = lt_s ? b : a;
      valu_pkg::VMAXU: elem_op = lt_u ? b : a;
      // Bits above w are dropped when the lane is written back
      valu_pkg::VSLL:  elem_op = a << shamt;
      valu_pkg::VSRL:  elem_op = a >> shamt;
      default:         elem_op = '0;
    endcase
  endfunction

  // Each lane works alone, no carry crosses an element
  always_comb begin
    result_o = '0;
    unique case (vew_i)
      valu_pkg::EW8: begin
        for (int i = 0; i < 8; i++) begin
          result_o.b[i] = 8'(elem_op(op_i, 64'(operand_a_i.b[i]),
                                     64'(operand_b_i.b[i]), 7'd8));
        end
      end
      valu_pkg::EW16: begin
        for (int i = 0; i < 4; i++) begin
          result_o.h[i] = 16'(elem_op(op_i, 64'(operand_a_i.h[i]),
                                      64'(operand_b_i.h[i]), 7'd16));
        end
      end
      valu_pkg::EW32: begin
        for (int i = 0; i < 2; i++) begin
          result_o.w[i] = 32'(elem_op(op_i, 64'(operand_a_i.w[i]),
                                      64'(operand_b_i.w[i]), 7'd32));
        end
      end
      default: begin
        result_o.d = elem_op(op_i, operand_a_i.d, operand_b_i.d, 7'd64);
      end
    endcase
  end

endmodule

// File: valu_tb.sv
////////////////////////////////////////
// Vector ALU lane testbench
////////////////////////////////////////

`timescale 1ns/1ns

`include "valu_settings.svh"

module valu_tb;

  localparam int NUM_INSNS = 88;

  // Expected register file write
  typedef struct packed {
    valu_pkg::vaddr_t addr;
    logic [63:0]      wdata;
    logic [7:0]       be;
    valu_pkg::vid_t   id;
    logic             last;
  } expect_t;

  logic                        clk_i             = 1'b0;
  logic                        rst_ni            = 1'b0;
  logic                        insn_valid_i      = 1'b0;
  valu_pkg::valu_op_e          insn_op_i         = valu_pkg::VADD;
  valu_pkg::vew_e              insn_vew_i        = valu_pkg::EW8;
  valu_pkg::vlen_t             insn_vl_i         = '0;
  valu_pkg::vreg_t             insn_vd_i         = '0;
  valu_pkg::vid_t              insn_id_i         = '0;
  logic                        insn_use_scalar_i = 1'b0;
  logic [63:0]                 insn_scalar_i     = '0;
  logic                        insn_ready_o;
  logic [63:0]                 operand_a_i       = '0;
  logic                        operand_a_valid_i = 1'b0;
  logic                        operand_a_ready_o;
  logic [63:0]                 operand_b_i       = '0;
  logic                        operand_b_valid_i = 1'b0;
  logic                        operand_b_ready_o;
  logic                        result_req_o;
  valu_pkg::vid_t              result_id_o;
  logic [`VALU_ADDR_WIDTH-1:0] result_addr_o;
  logic [63:0]                 result_wdata_o;
  logic [7:0]                  result_be_o;
  logic                        result_gnt_i      = 1'b0;
  logic [`VALU_NR_IDS-1:0]     vinsn_done_o;

  integer seed = 32'h3c1552de;

  // Instruction list built before reset
  valu_pkg::valu_op_e op_arr     [NUM_INSNS];
  valu_pkg::vew_e     vew_arr    [NUM_INSNS];
  int                 vl_arr     [NUM_INSNS];
  int                 vd_arr     [NUM_INSNS];
  logic               scalar_en  [NUM_INSNS];
  logic [63:0]        scalar_arr [NUM_INSNS];

  logic [63:0] a_words [$];
  logic [63:0] b_words [$];
  expect_t     exp_q   [$];

  int total_words = 0;
  int granted     = 0;
  int done_count  = 0;
  int outstanding = 0;
  int gnt_wait    = 0;
  int checks      = 0;
  int errors      = 0;
  logic full_seen = 1'b0;

  expect_t                 cur;
  logic [`VALU_NR_IDS-1:0] done_exp = '0;
  logic [`VALU_NR_IDS-1:0] next_done;

  valu dut (.*);

  initial begin
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Sign of each element taken from its top bit
  function automatic logic [63:0] ref_word(valu_pkg::valu_op_e op, valu_pkg::vew_e vew,
                                           logic [63:0] a, logic [63:0] b);
    int          w;
    int          i;
    logic [63:0] m;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] r;
    logic [63:0] res;
    longint      sa;
    longint      sb;
    w   = 8 << int'(vew);
    m   = (w == 64) ? '1 : ((64'd1 << w) - 1);
    res = '0;
    for (i = 0; i < 64 / w; i++) begin
      ea = (a >> (i * w)) & m;
      eb = (b >> (i * w)) & m;
      sa = longint'(ea << (64 - w)) >>> (64 - w);
      sb = longint'(eb << (64 - w)) >>> (64 - w);
      case (op)
        valu_pkg::VADD:  r = ea + eb;
        valu_pkg::VSUB:  r = ea - eb;
        valu_pkg::VAND:  r = ea & eb;
        valu_pkg::VOR:   r = ea | eb;
        valu_pkg::VXOR:  r = ea ^ eb;
        valu_pkg::VMIN:  r = (sa < sb) ? ea : eb;
        valu_pkg::VMINU: r = (ea < eb) ? ea : eb;
        valu_pkg::VMAX:  r = (sa > sb) ? ea : eb;
        valu_pkg::VMAXU: r = (ea > eb) ? ea : eb;
        valu_pkg::VSLL:  r = ea << (eb % w);
        valu_pkg::VSRL:  r = ea >> (eb % w);
        default:         r = '0;
      endcase
      res = res | ((r & m) << (i * w));
    end
    return res;
  endfunction

  // Low scalar element in every lane
  function automatic logic [63:0] replicate(valu_pkg::vew_e vew, logic [63:0] s);
    int          w;
    int          i;
    logic [63:0] m;
    logic [63:0] r;
    w = 8 << int'(vew);
    m = (w == 64) ? '1 : ((64'd1 << w) - 1);
    r = '0;
    for (i = 0; i < 64 / w; i++) begin
      r = r | ((s & m) << (i * w));
    end
    return r;
  endfunction

  function automatic logic [63:0] byte_mask(logic [7:0] be);
    logic [63:0] m;
    int          i;
    for (i = 0; i < 8; i++) begin
      m[i*8 +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  // Operand words and expected writes of one instruction
  task automatic load_words(input int n);
    int          epw;
    int          nw;
    int          k;
    int          cnt;
    logic [63:0] a;
    logic [63:0] b;
    expect_t     e;
    epw = 8 >> int'(vew_arr[n]);
    nw  = (vl_arr[n] + epw - 1) / epw;
    for (k = 0; k < nw; k++) begin
      b = {$random(seed), $random(seed)};
      b_words.push_back(b);
      if (scalar_en[n]) begin
        a = replicate(vew_arr[n], scalar_arr[n]);
      end else begin
        a = {$random(seed), $random(seed)};
        a_words.push_back(a);
      end
      // Tail word enables only the elements left
      cnt = vl_arr[n] - k * epw;
      if (cnt > epw) begin
        cnt = epw;
      end
      e.be    = 8'((16'd1 << (cnt << int'(vew_arr[n]))) - 1);
      e.addr  = valu_pkg::vaddr_t'(vd_arr[n] * `VALU_REG_WORDS + k);
      e.id    = valu_pkg::vid_t'(n % `VALU_NR_IDS);
      e.last  = (k == nw - 1);
      e.wdata = ref_word(op_arr[n], vew_arr[n], a, b) & byte_mask(e.be);
      exp_q.push_back(e);
    end
  endtask

  ////////////////////////////////////////
  // Operand streams and grants
  ////////////////////////////////////////

  // Presented word held until consumed
  // Random bubbles only between words
  always @(posedge clk_i) begin
    if (operand_a_valid_i && operand_a_ready_o) begin
      void'(a_words.pop_front());
    end
    if (!operand_a_valid_i || operand_a_ready_o) begin
      if (rst_ni && a_words.size() > 0 && ($unsigned($random(seed)) % 4) != 0) begin
        operand_a_valid_i <= 1'b1;
        operand_a_i       <= a_words[0];
      end else begin
        operand_a_valid_i <= 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    if (operand_b_valid_i && operand_b_ready_o) begin
      void'(b_words.pop_front());
    end
    if (!operand_b_valid_i || operand_b_ready_o) begin
      if (rst_ni && b_words.size() > 0 && ($unsigned($random(seed)) % 4) != 0) begin
        operand_b_valid_i <= 1'b1;
        operand_b_i       <= b_words[0];
      end else begin
        operand_b_valid_i <= 1'b0;
      end
    end
  end

  // Grant after 0 to 3 idle cycles
  // Grant dropped after each transfer
  always @(posedge clk_i) begin
    if (!rst_ni || result_gnt_i) begin
      result_gnt_i <= 1'b0;
      gnt_wait     <= $unsigned($random(seed)) % 4;
    end else if (result_req_o) begin
      if (gnt_wait == 0) begin
        result_gnt_i <= 1'b1;
      end else begin
        gnt_wait <= gnt_wait - 1;
      end
    end
  end

  ////////////////////////////////////////
  // Compare
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // Done pulse one cycle after the last word's grant
      checks++;
      if (vinsn_done_o !== done_exp) begin
        errors++;
        $display("CHECK FAILED vinsn_done_o: got %h expected %h", vinsn_done_o, done_exp);
      end
      done_count += $countones(vinsn_done_o);
      // Ready low only with a full instruction queue
      checks++;
      if (insn_ready_o !== (outstanding < `VALU_INSN_DEPTH)) begin
        errors++;
        $display("CHECK FAILED insn_ready_o: got %h expected %h", insn_ready_o,
                 outstanding < `VALU_INSN_DEPTH);
      end
      if (!insn_ready_o) begin
        full_seen = 1'b1;
      end
      if (insn_valid_i && insn_ready_o) begin
        outstanding++;
      end
      next_done = '0;
      if (result_req_o && result_gnt_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Result word granted with no word left to expect");
        end else begin
          cur = exp_q.pop_front();
          granted++;
          checks += 4;
          if (result_addr_o !== cur.addr) begin
            errors++;
            $display("CHECK FAILED result_addr_o: got %h expected %h", result_addr_o, cur.addr);
          end
          if (result_be_o !== cur.be) begin
            errors++;
            $display("CHECK FAILED result_be_o: got %h expected %h", result_be_o, cur.be);
          end
          if (result_id_o !== cur.id) begin
            errors++;
            $display("CHECK FAILED result_id_o: got %h expected %h", result_id_o, cur.id);
          end
          if ((result_wdata_o & byte_mask(cur.be)) !== cur.wdata) begin
            errors++;
            $display("CHECK FAILED result_wdata_o: got %h expected %h",
                     result_wdata_o & byte_mask(cur.be), cur.wdata);
          end
          if (cur.last) begin
            next_done[cur.id] = 1'b1;
            outstanding--;
          end
        end
      end
      done_exp = next_done;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : main
    int n;
    int vmax;
    // Every op at every width
    // Second pass uses the scalar operand
    for (n = 0; n < NUM_INSNS; n++) begin
      op_arr[n]     = valu_pkg::valu_op_e'(n % 11);
      vew_arr[n]    = valu_pkg::vew_e'((n / 11) % 4);
      vmax          = `VALU_MAX_VL >> int'(vew_arr[n]);
      vl_arr[n]     = (n % 5 == 0) ? vmax : 1 + $unsigned($random(seed)) % vmax;
      vd_arr[n]     = $unsigned($random(seed)) % 32;
      scalar_en[n]  = (n >= NUM_INSNS / 2);
      scalar_arr[n] = {$random(seed), $random(seed)};
      total_words  += (vl_arr[n] + (8 >> int'(vew_arr[n])) - 1) / (8 >> int'(vew_arr[n]));
    end
    repeat (16) @(posedge clk_i);
    checks++;
    if (result_req_o !== 1'b0 || vinsn_done_o !== '0 || operand_a_ready_o !== 1'b0 ||
        operand_b_ready_o !== 1'b0 || insn_ready_o !== 1'b1) begin
      errors++;
      $display("Outputs are not at their reset values during reset");
    end
    rst_ni <= 1'b1;
    for (n = 0; n < NUM_INSNS; n++) begin
      load_words(n);
      insn_valid_i      <= 1'b1;
      insn_op_i         <= op_arr[n];
      insn_vew_i        <= vew_arr[n];
      insn_vl_i         <= valu_pkg::vlen_t'(vl_arr[n]);
      insn_vd_i         <= valu_pkg::vreg_t'(vd_arr[n]);
      insn_id_i         <= valu_pkg::vid_t'(n % `VALU_NR_IDS);
      insn_use_scalar_i <= scalar_en[n];
      insn_scalar_i     <= scalar_arr[n];
      @(posedge clk_i);
      while (!insn_ready_o) begin
        @(posedge clk_i);
      end
    end
    insn_valid_i <= 1'b0;
    while (done_count < NUM_INSNS) begin
      @(posedge clk_i);
    end
    // Quiet tail to catch stray done pulses
    repeat (8) @(posedge clk_i);
    if (exp_q.size() != 0 || a_words.size() != 0 || b_words.size() != 0) begin
      errors++;
      $display("Words left over at the end: %0d results, %0d a and %0d b operands",
               exp_q.size(), a_words.size(), b_words.size());
    end
    if (!full_seen) begin
      errors++;
      $display("The instruction queue never filled up");
    end
    $display("Words %0d of %0d, done pulses %0d, checks %0d, errors %0d",
             granted, total_words, done_count, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Run limit scales with the words sent
  initial begin : watchdog
    int limit;
    wait (total_words != 0);
    limit = 200 * total_words + 1000;
    repeat (limit) @(posedge clk_i);
    $display("Timeout after %0d cycles with %0d of %0d result words granted",
             limit, granted, total_words);
    $display("TEST FAILED");
    $finish;
  end

endmodule
